/* ex_stage.f */
+incdir+hdl
hdl/ex_pkg.sv
hdl/alu.sv
hdl/mult.sv
hdl/ex_issue.sv
hdl/ex_writeback.sv
hdl/ex_stage.sv
dv/ex_stage_tb.sv

/* dv/ex_stage_tb.sv */
`timescale 1ns/100ps
`include "ex_macros.svh"

module ex_stage_tb;

    localparam int NUM_TESTS       = 20;
    localparam int RESET_CYCLES    = 10;
    localparam int WATCHDOG_CYCLES = NUM_TESTS * 50;
    localparam int NUM_ISSUES      = 2 * NUM_TESTS + 4 + 8;  // All four phases
    localparam int READY_HIGH      = 0;
    localparam int READY_LOW       = 1;
    localparam int READY_RANDOM    = 2;

    logic                      clk = 1'b0;
    logic                      rst_i;
    logic                      issue_valid_i;
    logic                      issue_ready_o;
    ex_pkg::fu_op_e            issue_op_i;
    logic [`XLEN-1:0]          issue_a_i;
    logic [`XLEN-1:0]          issue_b_i;
    logic [`TRANS_ID_BITS-1:0] issue_trans_id_i;
    logic                      wb_valid_o;
    logic                      wb_ready_i = 1'b1;
    logic [`XLEN-1:0]          wb_result_o;
    logic [`TRANS_ID_BITS-1:0] wb_trans_id_o;

    // Stimulus table with hand-computed results
    string                     name_tab [NUM_TESTS];
    ex_pkg::fu_op_e            op_tab   [NUM_TESTS];
    logic [`XLEN-1:0]          a_tab    [NUM_TESTS];
    logic [`XLEN-1:0]          b_tab    [NUM_TESTS];
    logic [`XLEN-1:0]          exp_tab  [NUM_TESTS];
    int                        fill_cnt = 0;

    // Bookkeeping per transaction ID
    logic                      pending      [2**`TRANS_ID_BITS];
    int                        idx_by_id    [2**`TRANS_ID_BITS];
    int                        accept_cycle [2**`TRANS_ID_BITS];
    int                        pop_order    [2**`TRANS_ID_BITS];

    int                        cur_idx;               // Table row on the issue port
    int                        cycle = 0;
    int                        outstanding = 0;
    int                        accept_count = 0;
    int                        pop_count = 0;
    int                        errors = 0;
    int                        pop_idx;
    int                        base;
    int                        ready_mode = READY_HIGH;
    logic                      lat_check = 1'b0;
    logic                      stuck_high;
    logic [31:0]               lcg_state = 32'h9665;

    ex_stage u_dut (
        .clk_i            ( clk              ),
        .rst_i            ( rst_i            ),
        .issue_valid_i    ( issue_valid_i    ),
        .issue_ready_o    ( issue_ready_o    ),
        .issue_op_i       ( issue_op_i       ),
        .issue_a_i        ( issue_a_i        ),
        .issue_b_i        ( issue_b_i        ),
        .issue_trans_id_i ( issue_trans_id_i ),
        .wb_valid_o       ( wb_valid_o       ),
        .wb_ready_i       ( wb_ready_i       ),
        .wb_result_o      ( wb_result_o      ),
        .wb_trans_id_o    ( wb_trans_id_o    )
    );

    always #10 clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Cycles from acceptance to the popping edge with the output always ready
    function automatic int latency_of(input ex_pkg::fu_op_e op);
        ex_pkg::fu_e unit;
        unit = (op == ex_pkg::OP_MUL || op == ex_pkg::OP_MULHU) ? ex_pkg::FU_MULT
                                                                 : ex_pkg::FU_ALU;
        return (unit == ex_pkg::FU_MULT) ? `MULT_STAGES + 1 : 2;
    endfunction

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("Error: %s expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic add_entry(input string name, input ex_pkg::fu_op_e op,
                             input logic [63:0] a, input logic [63:0] b,
                             input logic [63:0] exp);
        name_tab[fill_cnt] = name;
        op_tab[fill_cnt]   = op;
        a_tab[fill_cnt]    = a;
        b_tab[fill_cnt]    = b;
        exp_tab[fill_cnt]  = exp;
        fill_cnt++;
    endtask

    task automatic fill_table();
        add_entry("add",        ex_pkg::OP_ADD,   64'd5, 64'd7, 64'hc);
        add_entry("sub_neg",    ex_pkg::OP_SUB,   64'd3, 64'd10, 64'hffff_ffff_ffff_fff9);
        add_entry("and",        ex_pkg::OP_AND,   64'hf0f0_f0f0_f0f0_f0f0,
                  64'hff00_ff00_ff00_ff00, 64'hf000_f000_f000_f000);
        add_entry("or",         ex_pkg::OP_OR,    64'hf0f0_f0f0_f0f0_f0f0,
                  64'hff00_ff00_ff00_ff00, 64'hfff0_fff0_fff0_fff0);
        add_entry("xor",        ex_pkg::OP_XOR,   64'hf0f0_f0f0_f0f0_f0f0,
                  64'hff00_ff00_ff00_ff00, 64'h0ff0_0ff0_0ff0_0ff0);
        add_entry("sll",        ex_pkg::OP_SLL,   64'd1, 64'd63, 64'h8000_0000_0000_0000);
        add_entry("sll_mask",   ex_pkg::OP_SLL,   64'd3, 64'h44, 64'h30);  // Only 6 bits used
        add_entry("srl",        ex_pkg::OP_SRL,   64'h8000_0000_0000_0000, 64'd4,
                  64'h0800_0000_0000_0000);
        add_entry("sra_neg",    ex_pkg::OP_SRA,   64'h8000_0000_0000_0000, 64'd4,
                  64'hf800_0000_0000_0000);
        add_entry("sra_pos",    ex_pkg::OP_SRA,   64'h7000_0000_0000_0000, 64'd4,
                  64'h0700_0000_0000_0000);
        add_entry("slt",        ex_pkg::OP_SLT,   64'hffff_ffff_ffff_ffff, 64'd1, 64'd1);
        add_entry("sltu",       ex_pkg::OP_SLTU,  64'hffff_ffff_ffff_ffff, 64'd1, 64'd0);
        add_entry("eq_true",    ex_pkg::OP_EQ,    64'h1234_5678_9abc_def0,
                  64'h1234_5678_9abc_def0, 64'd1);
        add_entry("eq_false",   ex_pkg::OP_EQ,    64'h1234_5678_9abc_def0,
                  64'h1234_5678_9abc_def1, 64'd0);
        add_entry("mul",        ex_pkg::OP_MUL,   64'd6, 64'd7, 64'h2a);
        add_entry("mul_big",    ex_pkg::OP_MUL,   64'h1_0000_0000, 64'h1_0000_0003,
                  64'h3_0000_0000);
        add_entry("mulhu_big",  ex_pkg::OP_MULHU, 64'h1_0000_0000, 64'h1_0000_0003, 64'd1);
        add_entry("mul_ones",   ex_pkg::OP_MUL,   64'hffff_ffff_ffff_ffff,
                  64'hffff_ffff_ffff_ffff, 64'd1);
        add_entry("mulhu_ones", ex_pkg::OP_MULHU, 64'hffff_ffff_ffff_ffff,
                  64'hffff_ffff_ffff_ffff, 64'hffff_ffff_ffff_fffe);
        add_entry("add_wrap",   ex_pkg::OP_ADD,   64'hffff_ffff_ffff_ffff, 64'd1, 64'd0);
    endtask

    task automatic drive_entry(input int idx);
        issue_valid_i    <= 1'b1;
        issue_op_i       <= op_tab[idx];
        issue_a_i        <= a_tab[idx];
        issue_b_i        <= b_tab[idx];
        issue_trans_id_i <= `TRANS_ID_BITS'(idx % 8);
        cur_idx          <= idx;
    endtask

    // Returns on the edge that takes the instruction
    task automatic wait_accept();
        do @(posedge clk); while (!issue_ready_o);
    endtask

    task automatic issue_entry(input int idx);
        drive_entry(idx);
        wait_accept();
    endtask

    task automatic idle();
        issue_valid_i <= 1'b0;
    endtask

    // Extra edges let the last credit get home
    task automatic wait_idle();
        do @(negedge clk); while (outstanding != 0);
        repeat (2) @(posedge clk);
    endtask

    always @(posedge clk) begin
        case (ready_mode)
            READY_HIGH: wb_ready_i <= 1'b1;
            READY_LOW:  wb_ready_i <= 1'b0;
            default: begin
                lcg_state  <= lcg_next(lcg_state);
                wb_ready_i <= lcg_state[31];
            end
        endcase
    end

    // Acceptance monitor
    always @(posedge clk) begin
        if (!rst_i && issue_valid_i && issue_ready_o) begin
            if (pending[issue_trans_id_i]) begin
                errors++;
                $display("Transaction ID %0d was accepted again before its result left",
                         issue_trans_id_i);
            end
            pending[issue_trans_id_i]      = 1'b1;
            idx_by_id[issue_trans_id_i]    = cur_idx;
            accept_cycle[issue_trans_id_i] = cycle;
            outstanding++;
            accept_count++;
        end
    end

    // Result monitor, matched by transaction ID
    always @(posedge clk) begin
        if (!rst_i && wb_valid_o && wb_ready_i) begin
            pop_count++;
            if (!pending[wb_trans_id_o]) begin
                errors++;
                $display("A result with transaction ID %0d came out but none was outstanding",
                         wb_trans_id_o);
            end else begin
                pop_idx = idx_by_id[wb_trans_id_o];
                check(name_tab[pop_idx], exp_tab[pop_idx], wb_result_o);
                if (lat_check) begin
                    check({name_tab[pop_idx], " latency"}, latency_of(op_tab[pop_idx]),
                          cycle - accept_cycle[wb_trans_id_o]);
                end
                pop_order[wb_trans_id_o] = pop_count;
                pending[wb_trans_id_o]   = 1'b0;
                outstanding--;
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles with %0d results still missing",
                 WATCHDOG_CYCLES, outstanding);
        $display("Results checked: %0d, errors: %0d", pop_count, errors);
        $display("Something failed");
        $finish;
    end

    initial begin
        fill_table();
        for (int i = 0; i < 2**`TRANS_ID_BITS; i++) begin
            pending[i]   = 1'b0;
            pop_order[i] = 0;
        end
        rst_i            = 1'b1;
        issue_valid_i    = 1'b0;
        issue_op_i       = ex_pkg::OP_ADD;
        issue_a_i        = '0;
        issue_b_i        = '0;
        issue_trans_id_i = '0;
        cur_idx          = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_i <= 1'b0;
        @(posedge clk);

        // One at a time with the output always ready
        lat_check = 1'b1;
        for (int i = 0; i < NUM_TESTS; i++) begin
            issue_entry(i);
            idle();
            wait_idle();
        end
        lat_check = 1'b0;

        // Multiply then three ALU ops back to back
        issue_entry(14);
        issue_entry(0);
        issue_entry(1);
        issue_entry(2);
        idle();
        wait_idle();
        check("alu_passes_mul", 64'd1, 64'(pop_order[6] > pop_order[0]));

        // Stalled output must starve issue after WB_DEPTH acceptances
        ready_mode <= READY_LOW;
        repeat (2) @(posedge clk);
        base       = accept_count;
        stuck_high = 1'b0;
        for (int i = 2; i < 2 + `WB_DEPTH; i++) begin
            issue_entry(i);
        end
        drive_entry(2 + `WB_DEPTH);
        repeat (8) begin
            @(negedge clk);
            if (issue_ready_o) stuck_high = 1'b1;
        end
        if (stuck_high) begin
            errors++;
            $display("issue_ready_o stayed high while the writeback buffer was full");
        end
        check("credits_spent", `WB_DEPTH, accept_count - base);
        ready_mode <= READY_HIGH;
        wait_accept();
        for (int i = 3 + `WB_DEPTH; i < 10; i++) begin
            issue_entry(i);
        end
        idle();
        wait_idle();
        check("backpressure_count", 8, accept_count - base);

        // Whole table under random back-pressure
        ready_mode <= READY_RANDOM;
        for (int i = 0; i < NUM_TESTS; i++) begin
            issue_entry(i);
        end
        idle();
        wait_idle();
        ready_mode <= READY_HIGH;

        check("accepted_total", NUM_ISSUES, accept_count);
        check("popped_total", accept_count, pop_count);
        $display("Results checked: %0d, errors: %0d", pop_count, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* hdl/ex_stage.sv */
`timescale 1ns/100ps
`include "ex_macros.svh"

module ex_stage (
    input  logic                      clk_i,
    input  logic                      rst_i,
    // Instruction input
    input  logic                      issue_valid_i,
    output logic                      issue_ready_o,
    input  ex_pkg::fu_op_e            issue_op_i,
    input  logic [`XLEN-1:0]          issue_a_i,
    input  logic [`XLEN-1:0]          issue_b_i,
    input  logic [`TRANS_ID_BITS-1:0] issue_trans_id_i,
    // Results, possibly out of issue order
    output logic                      wb_valid_o,
    input  logic                      wb_ready_i,
    output logic [`XLEN-1:0]          wb_result_o,
    output logic [`TRANS_ID_BITS-1:0] wb_trans_id_o
);

    logic                      alu_valid;
    ex_pkg::fu_op_e            alu_op;
    logic [`XLEN-1:0]          alu_a;
    logic [`XLEN-1:0]          alu_b;
    logic [`TRANS_ID_BITS-1:0] alu_trans_id;
    logic [`XLEN-1:0]          alu_result;

    logic                      mult_valid;
    ex_pkg::fu_op_e            mult_op;
    logic [`XLEN-1:0]          mult_a;
    logic [`XLEN-1:0]          mult_b;
    logic [`TRANS_ID_BITS-1:0] mult_trans_id;
    logic                      mult_res_valid;
    logic [`XLEN-1:0]          mult_res;
    logic [`TRANS_ID_BITS-1:0] mult_res_trans_id;

    logic                      credit_return;

    ex_issue u_issue (
        .clk_i            ( clk_i            ),
        .rst_i            ( rst_i            ),
        .issue_valid_i    ( issue_valid_i    ),
        .issue_ready_o    ( issue_ready_o    ),
        .issue_op_i       ( issue_op_i       ),
        .issue_a_i        ( issue_a_i        ),
        .issue_b_i        ( issue_b_i        ),
        .issue_trans_id_i ( issue_trans_id_i ),
        .credit_return_i  ( credit_return    ),
        .alu_valid_o      ( alu_valid        ),
        .alu_op_o         ( alu_op           ),
        .alu_a_o          ( alu_a            ),
        .alu_b_o          ( alu_b            ),
        .alu_trans_id_o   ( alu_trans_id     ),
        .mult_valid_o     ( mult_valid       ),
        .mult_op_o        ( mult_op          ),
        .mult_a_o         ( mult_a           ),
        .mult_b_o         ( mult_b           ),
        .mult_trans_id_o  ( mult_trans_id    )
    );

    // Single cycle, result goes straight to writeback port A
    alu u_alu (
        .op_i     ( alu_op     ),
        .a_i      ( alu_a      ),
        .b_i      ( alu_b      ),
        .result_o ( alu_result )
    );

    mult u_mult (
        .clk_i      ( clk_i             ),
        .rst_i      ( rst_i             ),
        .valid_i    ( mult_valid        ),
        .op_i       ( mult_op           ),
        .a_i        ( mult_a            ),
        .b_i        ( mult_b            ),
        .trans_id_i ( mult_trans_id     ),
        .valid_o    ( mult_res_valid    ),
        .result_o   ( mult_res          ),
        .trans_id_o ( mult_res_trans_id )
    );

    ex_writeback u_wb (
        .clk_i           ( clk_i             ),
        .rst_i           ( rst_i             ),
        .a_valid_i       ( alu_valid         ),
        .a_result_i      ( alu_result        ),
        .a_trans_id_i    ( alu_trans_id      ),
        .b_valid_i       ( mult_res_valid    ),
        .b_result_i      ( mult_res          ),
        .b_trans_id_i    ( mult_res_trans_id ),
        .wb_valid_o      ( wb_valid_o        ),
        .wb_ready_i      ( wb_ready_i        ),
        .wb_result_o     ( wb_result_o       ),
        .wb_trans_id_o   ( wb_trans_id_o     ),
        .credit_return_o ( credit_return     )
    );

endmodule

/* hdl/ex_writeback.sv */
`timescale 1ns/100ps
`include "ex_macros.svh"

module ex_writeback (
    input  logic                      clk_i,
    input  logic                      rst_i,
    // Port A from the ALU
    input  logic                      a_valid_i,
    input  logic [`XLEN-1:0]          a_result_i,
    input  logic [`TRANS_ID_BITS-1:0] a_trans_id_i,
    // Port B from the multiplier
    input  logic                      b_valid_i,
    input  logic [`XLEN-1:0]          b_result_i,
    input  logic [`TRANS_ID_BITS-1:0] b_trans_id_i,
    // Result output
    output logic                      wb_valid_o,
    input  logic                      wb_ready_i,
    output logic [`XLEN-1:0]          wb_result_o,
    output logic [`TRANS_ID_BITS-1:0] wb_trans_id_o,
    output logic                      credit_return_o
);

    localparam int PTR_BITS = $clog2(`WB_DEPTH);
    localparam int ENTRY_W  = `TRANS_ID_BITS + `XLEN;

    logic [ENTRY_W-1:0]      mem_q [`WB_DEPTH];  // {trans_id, result}
    logic [PTR_BITS-1:0]     wr_ptr_q;
    logic [PTR_BITS-1:0]     rd_ptr_q;
    logic [`CREDIT_BITS-1:0] count_q;
    logic                    credit_q;
    logic                    pop;
    logic [1:0]              n_wr;
    logic [PTR_BITS-1:0]     a_slot;

    assign n_wr = {1'b0, a_valid_i} + {1'b0, b_valid_i};

    // Port B takes the earlier slot when both write
    assign a_slot = wr_ptr_q + PTR_BITS'(b_valid_i);

    always_ff @(posedge clk_i) begin
        if (b_valid_i) begin
            mem_q[wr_ptr_q] <= {b_trans_id_i, b_result_i};
        end
        if (a_valid_i) begin
            mem_q[a_slot] <= {a_trans_id_i, a_result_i};
        end
    end

    assign wb_valid_o                   = (count_q != '0);
    assign {wb_trans_id_o, wb_result_o} = mem_q[rd_ptr_q];
    assign pop                          = wb_valid_o & wb_ready_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            credit_q <= 1'b0;
        end else begin
            wr_ptr_q <= wr_ptr_q + PTR_BITS'(n_wr);  // Wraps at depth
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            count_q  <= count_q + `CREDIT_BITS'(n_wr) - `CREDIT_BITS'(pop);
            credit_q <= pop;  // Slot handed back one edge after the pop
        end
    end

    assign credit_return_o = credit_q;

    // Every incoming result must own a credit, so a full buffer never takes a write
    a_wb_no_overflow: assert property (@(posedge clk_i) disable iff (rst_i)
        int'(count_q) + int'(n_wr) <= `WB_DEPTH);

endmodule

/* hdl/ex_issue.sv */
`timescale 1ns/100ps
`include "ex_macros.svh"

module ex_issue (
    input  logic                      clk_i,
    input  logic                      rst_i,
    // Instruction input
    input  logic                      issue_valid_i,
    output logic                      issue_ready_o,
    input  ex_pkg::fu_op_e            issue_op_i,
    input  logic [`XLEN-1:0]          issue_a_i,
    input  logic [`XLEN-1:0]          issue_b_i,
    input  logic [`TRANS_ID_BITS-1:0] issue_trans_id_i,
    // One pulse per freed writeback slot
    input  logic                      credit_return_i,
    // To ALU
    output logic                      alu_valid_o,
    output ex_pkg::fu_op_e            alu_op_o,
    output logic [`XLEN-1:0]          alu_a_o,
    output logic [`XLEN-1:0]          alu_b_o,
    output logic [`TRANS_ID_BITS-1:0] alu_trans_id_o,
    // To multiplier
    output logic                      mult_valid_o,
    output ex_pkg::fu_op_e            mult_op_o,
    output logic [`XLEN-1:0]          mult_a_o,
    output logic [`XLEN-1:0]          mult_b_o,
    output logic [`TRANS_ID_BITS-1:0] mult_trans_id_o
);

    logic [`CREDIT_BITS-1:0]   credits_q;     // Free writeback slots
    logic                      accept;
    ex_pkg::fu_op_e            op_q;
    logic [`XLEN-1:0]          a_q;
    logic [`XLEN-1:0]          b_q;
    logic [`TRANS_ID_BITS-1:0] id_q;
    logic                      alu_valid_q;
    logic                      mult_valid_q;

    assign issue_ready_o = (credits_q != '0);
    assign accept        = issue_valid_i & issue_ready_o;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            credits_q    <= `CREDIT_BITS'(`WB_DEPTH);
            alu_valid_q  <= 1'b0;
            mult_valid_q <= 1'b0;
        end else begin
            // Return and spend may coincide
            credits_q    <= credits_q + `CREDIT_BITS'(credit_return_i)
                                      - `CREDIT_BITS'(accept);
            alu_valid_q  <= accept && (ex_pkg::fu_of(issue_op_i) == ex_pkg::FU_ALU);
            mult_valid_q <= accept && (ex_pkg::fu_of(issue_op_i) == ex_pkg::FU_MULT);
        end
    end

    // Instruction register shared by both units
    always_ff @(posedge clk_i) begin
        if (accept) begin
            op_q <= issue_op_i;
            a_q  <= issue_a_i;
            b_q  <= issue_b_i;
            id_q <= issue_trans_id_i;
        end
    end

    assign alu_valid_o     = alu_valid_q;
    assign alu_op_o        = op_q;
    assign alu_a_o         = a_q;
    assign alu_b_o         = b_q;
    assign alu_trans_id_o  = id_q;

    assign mult_valid_o    = mult_valid_q;
    assign mult_op_o       = op_q;
    assign mult_a_o        = a_q;
    assign mult_b_o        = b_q;
    assign mult_trans_id_o = id_q;

    // An underflow wraps above WB_DEPTH and is caught here as well
    a_credit_range: assert property (@(posedge clk_i) disable iff (rst_i)
        credits_q <= `CREDIT_BITS'(`WB_DEPTH));

    // Writeback cannot free a slot while every credit is at home
    a_credit_spurious: assert property (@(posedge clk_i) disable iff (rst_i)
        credit_return_i |-> credits_q < `CREDIT_BITS'(`WB_DEPTH));

endmodule

/* hdl/mult.sv */
`timescale 1ns/100ps
`include "ex_macros.svh"

module mult (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      valid_i,
    input  ex_pkg::fu_op_e            op_i,
    input  logic [`XLEN-1:0]          a_i,
    input  logic [`XLEN-1:0]          b_i,
    input  logic [`TRANS_ID_BITS-1:0] trans_id_i,
    output logic                      valid_o,
    output logic [`XLEN-1:0]          result_o,
    output logic [`TRANS_ID_BITS-1:0] trans_id_o
);

    // Operand register in ex_issue is the first of MULT_STAGES
    localparam int NS   = `MULT_STAGES - 1;
    localparam int HALF = `XLEN / 2;
    localparam int PPW  = `XLEN + HALF;  // Partial product width

    logic                      valid_q [NS];
    logic [`TRANS_ID_BITS-1:0] id_q    [NS];
    logic                      high_q  [NS];   // Set for MULHU
    logic [PPW-1:0]            pp_lo_q;
    logic [PPW-1:0]            pp_hi_q;
    logic [2*`XLEN-1:0]        prod_q  [1:NS-1];
    logic [2*`XLEN-1:0]        prod_sum;

    // Recombine the two 64x32 partial products
    assign prod_sum = {{HALF{1'b0}}, pp_lo_q} + {pp_hi_q, {HALF{1'b0}}};

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < NS; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else begin
            valid_q[0] <= valid_i;
            for (int i = 1; i < NS; i++) begin
                valid_q[i] <= valid_q[i-1];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        id_q[0]   <= trans_id_i;
        high_q[0] <= (op_i == ex_pkg::OP_MULHU);
        pp_lo_q   <= a_i * b_i[HALF-1:0];
        pp_hi_q   <= a_i * b_i[`XLEN-1:HALF];
        for (int i = 1; i < NS; i++) begin
            id_q[i]   <= id_q[i-1];
            high_q[i] <= high_q[i-1];
        end
        prod_q[1] <= prod_sum;
        for (int i = 2; i < NS; i++) begin
            prod_q[i] <= prod_q[i-1];  // Extra latency only
        end
    end

    assign valid_o    = valid_q[NS-1];
    assign trans_id_o = id_q[NS-1];
    assign result_o   = high_q[NS-1] ? prod_q[NS-1][2*`XLEN-1:`XLEN]
                                     : prod_q[NS-1][`XLEN-1:0];

    // Issue steering must only send multiplies here
    a_mult_op: assert property (@(posedge clk_i) disable iff (rst_i)
        valid_i |-> ex_pkg::fu_of(op_i) == ex_pkg::FU_MULT);

endmodule

/* hdl/alu.sv */
`timescale 1ns/100ps
`include "ex_macros.svh"

module alu (
    input  ex_pkg::fu_op_e   op_i,
    input  logic [`XLEN-1:0] a_i,
    input  logic [`XLEN-1:0] b_i,
    output logic [`XLEN-1:0] result_o
);

    localparam int SHAMT_BITS = $clog2(`XLEN);

    logic                  sub;
    logic [`XLEN-1:0]      b_mux;
    logic [`XLEN:0]        adder_result;   // Top bit is carry out
    logic [SHAMT_BITS-1:0] shamt;
    logic                  less_signed;
    logic                  less_unsigned;
    logic                  is_equal;

    // Compares reuse the adder as a subtractor
    assign sub = (op_i == ex_pkg::OP_SUB)  || (op_i == ex_pkg::OP_SLT) ||
                 (op_i == ex_pkg::OP_SLTU) || (op_i == ex_pkg::OP_EQ);

    assign b_mux        = sub ? ~b_i : b_i;
    assign adder_result = {1'b0, a_i} + {1'b0, b_mux} + {{`XLEN{1'b0}}, sub};

    assign shamt = b_i[SHAMT_BITS-1:0];

    // No carry out means a borrow
    assign less_unsigned = ~adder_result[`XLEN];

    // Differing signs decide directly, otherwise sign of the difference
    assign less_signed = (a_i[`XLEN-1] != b_i[`XLEN-1]) ? a_i[`XLEN-1]
                                                       : adder_result[`XLEN-1];

    assign is_equal = (adder_result[`XLEN-1:0] == '0);

    always_comb begin
        case (op_i)
            ex_pkg::OP_ADD,
            ex_pkg::OP_SUB:  result_o = adder_result[`XLEN-1:0];
            ex_pkg::OP_AND:  result_o = a_i & b_i;
            ex_pkg::OP_OR:   result_o = a_i | b_i;
            ex_pkg::OP_XOR:  result_o = a_i ^ b_i;
            ex_pkg::OP_SLL:  result_o = a_i << shamt;
            ex_pkg::OP_SRL:  result_o = a_i >> shamt;
            ex_pkg::OP_SRA:  result_o = $unsigned($signed(a_i) >>> shamt);
            ex_pkg::OP_SLT:  result_o = {{(`XLEN-1){1'b0}}, less_signed};
            ex_pkg::OP_SLTU: result_o = {{(`XLEN-1){1'b0}}, less_unsigned};
            ex_pkg::OP_EQ:   result_o = {{(`XLEN-1){1'b0}}, is_equal};
            default:         result_o = '0;  // Multiplies never get here
        endcase
    end

endmodule

/* hdl/ex_pkg.sv */
package ex_pkg;

    // Opcodes seen by the execute stage
    typedef enum logic [3:0] {
        OP_ADD   = 4'h0,
        OP_SUB   = 4'h1,
        OP_AND   = 4'h2,
        OP_OR    = 4'h3,
        OP_XOR   = 4'h4,
        OP_SLL   = 4'h5,
        OP_SRL   = 4'h6,
        OP_SRA   = 4'h7,
        OP_SLT   = 4'h8,
        OP_SLTU  = 4'h9,
        OP_EQ    = 4'ha,
        OP_MUL   = 4'hb,  // Low half of product
        OP_MULHU = 4'hc   // High half, unsigned
    } fu_op_e;

    typedef enum logic [0:0] {
        FU_ALU  = 1'b0,
        FU_MULT = 1'b1
    } fu_e;

    // Steering decision for one opcode
    function automatic fu_e fu_of(input fu_op_e op);
        fu_e unit;
        case (op)
            OP_MUL, OP_MULHU: unit = FU_MULT;
            default:          unit = FU_ALU;
        endcase
        return unit;
    endfunction

endpackage

/* hdl/ex_macros.svh */
`ifndef EX_MACROS_SVH
`define EX_MACROS_SVH

// Datapath width
`define XLEN          64

// Transaction ID carried with every instruction
`define TRANS_ID_BITS 3

// Multiplier latency from acceptance to writeback, at least 3
`define MULT_STAGES   3

// Writeback slots, one credit each
// Power of two, no larger than 2**TRANS_ID_BITS
`define WB_DEPTH      4

// Must hold the value WB_DEPTH
`define CREDIT_BITS   3

`endif
